// ==== hw/rvc_frontend_pkg.sv ====
package rvc_frontend_pkg;

    // ====================
    // Widths
    // ====================

    localparam int XLEN        = 64;
    localparam int VADDR_W     = 39;
    localparam int ILEN        = 32;
    localparam int HALF_W      = 16;
    localparam int LINE_W      = 64;
    localparam int LINE_HALVES = LINE_W / HALF_W;
    // One line plus a carry halfword
    localparam int BUF_HALVES  = LINE_HALVES + 1;

    // Fetch starts here
    localparam logic [VADDR_W-1:0] RESET_PC = 39'h00_1000_0000;

    // ====================
    // Major opcodes
    // ====================

    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;

    // ====================
    // Instruction word views
    // ====================

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // Branch offset bits scattered over rd and funct7 slots
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        logic [ILEN-1:0] raw;
        r_fmt_t          r;
        i_fmt_t          i;
        s_fmt_t          s;
        b_fmt_t          b;
        u_fmt_t          u;
        j_fmt_t          j;
    } instr_word_u;

    typedef enum logic [3:0] {
        CLS_ALU,
        CLS_ALU_W,
        CLS_MUL,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH,
        CLS_JAL,
        CLS_JALR,
        CLS_SYSTEM,
        CLS_UNKNOWN
    } instr_class_e;

    // ====================
    // Stage payloads
    // ====================

    typedef struct packed {
        logic [VADDR_W-1:0] addr;
        logic [LINE_W-1:0]  data;
    } line_t;

    typedef struct packed {
        logic [VADDR_W-1:0] pc;
        logic [ILEN-1:0]    raw;
        logic               compressed;
    } aligned_instr_t;

    typedef struct packed {
        logic [VADDR_W-1:0] pc;
        logic [ILEN-1:0]    word;
        logic               compressed;
        logic               illegal;
    } expanded_instr_t;

    typedef struct packed {
        logic [VADDR_W-1:0] pc;
        logic [ILEN-1:0]    word;
        logic               compressed;
        logic               illegal;
        instr_class_e       cls;
        logic [4:0]         rd;
        logic [4:0]         rs1;
        logic [4:0]         rs2;
        logic [2:0]         funct3;
        logic [XLEN-1:0]    imm;
    } decoded_instr_t;

endpackage

// ==== hw/line_fetch.sv ====
module line_fetch import rvc_frontend_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               redirect,
    input  logic [VADDR_W-1:0] redirect_pc,
    output logic               mem_req,
    output logic [VADDR_W-1:0] mem_addr,
    input  logic               mem_ack,
    input  logic [LINE_W-1:0]  mem_rdata,
    output logic               line_valid,
    output line_t              line_out,
    input  logic               line_take
);

    // Idle, request open, waiting for ack to fall
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_REL
    } fetch_state_e;

    fetch_state_e       state_q;
    logic [VADDR_W-1:0] next_addr_q;
    logic [VADDR_W-1:0] req_addr_q;
    logic               drop_q;
    logic               slot_valid_q;
    line_t              slot_q;
    logic               start;
    logic               capture;

    // New request once the slot is free or being emptied
    assign start   = (state_q == ST_IDLE) && !redirect && (!slot_valid_q || line_take);
    // Data kept only if no redirect hit this transaction
    assign capture = (state_q == ST_REQ) && mem_ack && !drop_q && !redirect;

    assign mem_req    = (state_q == ST_REQ);
    assign mem_addr   = req_addr_q;
    assign line_valid = slot_valid_q;
    assign line_out   = slot_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= ST_IDLE;
            next_addr_q  <= RESET_PC;
            req_addr_q   <= RESET_PC;
            drop_q       <= 1'b0;
            slot_valid_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: if (start) state_q <= ST_REQ;
                ST_REQ:  if (mem_ack) state_q <= ST_REL;
                default: if (!mem_ack) state_q <= ST_IDLE;
            endcase

            // Address held on mem_addr while req is up
            if (start) begin
                req_addr_q <= next_addr_q;
            end

            if (redirect) begin
                next_addr_q <= {redirect_pc[VADDR_W-1:3], 3'b000};
            end else if (start) begin
                next_addr_q <= next_addr_q + VADDR_W'(8);
            end

            // Open request cut off by redirect finishes, data thrown away
            if (state_q == ST_REQ && mem_ack) begin
                drop_q <= 1'b0;
            end else if (state_q == ST_REQ && redirect) begin
                drop_q <= 1'b1;
            end

            if (redirect) begin
                slot_valid_q <= 1'b0;
            end else if (capture) begin
                slot_valid_q <= 1'b1;
            end else if (line_take) begin
                slot_valid_q <= 1'b0;
            end
        end
    end

    // Line payload
    always_ff @(posedge clk) begin
        if (capture) begin
            slot_q <= '{addr: req_addr_q, data: mem_rdata};
        end
    end

endmodule

// ==== hw/instr_aligner.sv ====
module instr_aligner import rvc_frontend_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               redirect,
    input  logic [VADDR_W-1:0] redirect_pc,
    input  logic               line_valid,
    input  line_t              line_in,
    output logic               line_take,
    output logic               al_valid,
    output aligned_instr_t     al_instr,
    input  logic               dec_ready
);

    // Head of the buffer is always halfword 0
    logic [BUF_HALVES-1:0][HALF_W-1:0] hw_q;
    logic [BUF_HALVES-1:0][HALF_W-1:0] hw_d;
    logic [BUF_HALVES-1:0][HALF_W-1:0] sh_hw;
    logic [BUF_HALVES-1:0]             hv_q;
    logic [BUF_HALVES-1:0]             hv_d;
    logic [BUF_HALVES-1:0]             sh_v;
    logic [VADDR_W-1:0]                pc_q;
    // Halfwords to skip in the first line after a redirect
    logic [1:0]                        skip_q;
    logic                              head_c;
    logic                              fire;
    logic [1:0]                        used;

    // ====================
    // Extraction
    // ====================

    // Low bits 11 mark a 32-bit instruction
    assign head_c   = (hw_q[0][1:0] != 2'b11);
    assign al_valid = hv_q[0] && (head_c || hv_q[1]);
    assign fire     = al_valid && dec_ready;
    assign used     = fire ? (head_c ? 2'd1 : 2'd2) : 2'd0;

    assign al_instr.pc         = pc_q;
    assign al_instr.raw        = head_c ? {{HALF_W{1'b0}}, hw_q[0]} : {hw_q[1], hw_q[0]};
    assign al_instr.compressed = head_c;

    // ====================
    // Buffer update
    // ====================

    always_comb begin
        logic [2:0] pos;
        pos = '0;

        // Drop consumed halfwords from the head
        for (int i = 0; i < BUF_HALVES; i++) begin
            if (i + int'(used) < BUF_HALVES) begin
                sh_hw[i] = hw_q[i + int'(used)];
                sh_v[i]  = hv_q[i + int'(used)];
            end else begin
                sh_hw[i] = hw_q[i];
                sh_v[i]  = 1'b0;
            end
        end

        // Room for a full line when at most a carry halfword remains
        line_take = line_valid && !sh_v[1] && !redirect;

        hw_d = sh_hw;
        hv_d = sh_v;
        if (line_take) begin
            for (int j = 0; j < LINE_HALVES; j++) begin
                if (j >= int'(skip_q)) begin
                    // Append behind the carry, if any
                    pos = 3'(j + int'(sh_v[0]) - int'(skip_q));
                    hw_d[pos] = line_in.data[j*HALF_W +: HALF_W];
                    hv_d[pos] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hv_q   <= '0;
            pc_q   <= RESET_PC;
            skip_q <= RESET_PC[2:1];
        end else if (redirect) begin
            hv_q   <= '0;
            pc_q   <= redirect_pc;
            skip_q <= redirect_pc[2:1];
        end else begin
            hv_q <= hv_d;
            if (line_take) begin
                skip_q <= 2'd0;
            end
            // Empty buffer restarts from the line address
            if (line_take && !sh_v[0]) begin
                pc_q <= {line_in.addr[VADDR_W-1:3], skip_q, 1'b0};
            end else if (fire) begin
                pc_q <= pc_q + (head_c ? VADDR_W'(2) : VADDR_W'(4));
            end
        end
    end

    // Halfword payload
    always_ff @(posedge clk) begin
        hw_q <= hw_d;
    end

endmodule

// ==== hw/rvc_expander.sv ====
module rvc_expander import rvc_frontend_pkg::*; (
    input  aligned_instr_t  al_instr,
    output expanded_instr_t exp_instr
);

    logic [HALF_W-1:0] c;
    logic [5:0]        imm6;
    logic [11:0]       off12;
    logic [4:0]        c_rd;
    logic [4:0]        c_rs2;
    instr_word_u       w;
    logic              ok;

    assign c     = al_instr.raw[HALF_W-1:0];
    assign c_rd  = c[11:7];
    assign c_rs2 = c[6:2];
    assign imm6  = {c[12], c[6:2]};

    // C.J offset, bit 0 implied
    assign off12 = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};

    always_comb begin
        w  = '0;
        ok = 1'b1;

        // Quadrant in bits 1:0, funct3 in bits 15:13
        case ({c[1:0], c[15:13]})
            // C.ADDI
            5'b01_000: begin
                w.i.imm    = {{6{imm6[5]}}, imm6};
                w.i.rs1    = c_rd;
                w.i.funct3 = 3'b000;
                w.i.rd     = c_rd;
                w.i.opcode = OPC_OP_IMM;
            end
            // C.LI
            5'b01_010: begin
                w.i.imm    = {{6{imm6[5]}}, imm6};
                w.i.rs1    = 5'd0;
                w.i.funct3 = 3'b000;
                w.i.rd     = c_rd;
                w.i.opcode = OPC_OP_IMM;
            end
            // C.J
            5'b01_101: begin
                w.j.imm20    = off12[11];
                w.j.imm19_12 = {8{off12[11]}};
                w.j.imm11    = off12[11];
                w.j.imm10_1  = off12[10:1];
                w.j.rd       = 5'd0;
                w.j.opcode   = OPC_JAL;
            end
            // C.MV and C.ADD, rs2 of zero is JR/JALR/EBREAK
            5'b10_100: begin
                if (c_rs2 == 5'd0) begin
                    ok = 1'b0;
                end else begin
                    w.r.funct7 = 7'd0;
                    w.r.rs2    = c_rs2;
                    // C.ADD reads rd, C.MV reads x0
                    w.r.rs1    = c[12] ? c_rd : 5'd0;
                    w.r.funct3 = 3'b000;
                    w.r.rd     = c_rd;
                    w.r.opcode = OPC_OP;
                end
            end
            default: ok = 1'b0;
        endcase
    end

    always_comb begin
        exp_instr.pc         = al_instr.pc;
        exp_instr.compressed = al_instr.compressed;
        if (!al_instr.compressed) begin
            // Full-width words pass through
            exp_instr.word    = al_instr.raw;
            exp_instr.illegal = 1'b0;
        end else begin
            exp_instr.word    = ok ? w.raw : '0;
            exp_instr.illegal = !ok;
        end
    end

endmodule

// ==== hw/instr_decoder.sv ====
module instr_decoder import rvc_frontend_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            redirect,
    input  logic            stall,
    input  logic            al_valid,
    input  expanded_instr_t exp_instr,
    output logic            dec_ready,
    output logic            out_valid,
    output decoded_instr_t  out_instr
);

    instr_word_u    w;
    decoded_instr_t dec;
    logic           valid_q;
    decoded_instr_t out_q;

    assign w = exp_instr.word;

    // ====================
    // Field and immediate decode
    // ====================

    always_comb begin
        dec            = '0;
        dec.pc         = exp_instr.pc;
        dec.word       = w.raw;
        dec.compressed = exp_instr.compressed;
        dec.illegal    = exp_instr.illegal;
        dec.rd         = w.r.rd;
        dec.rs1        = w.r.rs1;
        dec.rs2        = w.r.rs2;
        dec.funct3     = w.r.funct3;
        dec.cls        = CLS_UNKNOWN;

        case (w.r.opcode)
            OPC_LUI, OPC_AUIPC: begin
                dec.cls = CLS_ALU;
                dec.imm = {{(XLEN-32){w.u.imm[19]}}, w.u.imm, 12'h000};
            end
            OPC_JAL: begin
                dec.cls = CLS_JAL;
                dec.imm = {{(XLEN-21){w.j.imm20}}, w.j.imm20, w.j.imm19_12,
                           w.j.imm11, w.j.imm10_1, 1'b0};
            end
            OPC_BRANCH: begin
                dec.cls = CLS_BRANCH;
                dec.imm = {{(XLEN-13){w.b.imm12}}, w.b.imm12, w.b.imm11,
                           w.b.imm10_5, w.b.imm4_1, 1'b0};
            end
            OPC_STORE: begin
                dec.cls = CLS_STORE;
                dec.imm = {{(XLEN-12){w.s.imm_hi[6]}}, w.s.imm_hi, w.s.imm_lo};
            end
            // All I-format opcodes
            OPC_JALR, OPC_LOAD, OPC_OP_IMM, OPC_OP_IMM_32, OPC_SYSTEM: begin
                case (w.i.opcode)
                    OPC_JALR:      dec.cls = CLS_JALR;
                    OPC_LOAD:      dec.cls = CLS_LOAD;
                    OPC_OP_IMM_32: dec.cls = CLS_ALU_W;
                    OPC_SYSTEM:    dec.cls = CLS_SYSTEM;
                    default:       dec.cls = CLS_ALU;
                endcase
                dec.imm = {{(XLEN-12){w.i.imm[11]}}, w.i.imm};
            end
            // R-format, no immediate
            OPC_OP, OPC_OP_32: begin
                if (w.r.funct7 == 7'd1) begin
                    dec.cls = CLS_MUL;
                end else begin
                    dec.cls = (w.r.opcode == OPC_OP_32) ? CLS_ALU_W : CLS_ALU;
                end
            end
            default: dec.cls = CLS_UNKNOWN;
        endcase

        // Illegal compressed words decode as nothing
        if (exp_instr.illegal) begin
            dec.cls = CLS_UNKNOWN;
            dec.imm = '0;
        end
    end

    // ====================
    // Output register
    // ====================

    // Free when empty or handed over this cycle
    assign dec_ready = !valid_q || !stall;
    assign out_valid = valid_q;
    assign out_instr = out_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (redirect) begin
            valid_q <= 1'b0;
        end else if (dec_ready) begin
            valid_q <= al_valid;
        end
    end

    // Held under stall
    always_ff @(posedge clk) begin
        if (dec_ready && al_valid) begin
            out_q <= dec;
        end
    end

endmodule

// ==== hw/rvc_frontend.sv ====
module rvc_frontend import rvc_frontend_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,
    input  logic               redirect,
    input  logic [VADDR_W-1:0] redirect_pc,
    output logic               mem_req,
    output logic [VADDR_W-1:0] mem_addr,
    input  logic               mem_ack,
    input  logic [LINE_W-1:0]  mem_rdata,
    output logic               out_valid,
    output decoded_instr_t     out_instr
);

    // Fetch to aligner
    logic            line_valid;
    logic            line_take;
    line_t           line;

    // Aligner to expander and decoder
    logic            al_valid;
    logic            dec_ready;
    aligned_instr_t  al_instr;
    expanded_instr_t exp_instr;

    line_fetch fetch_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_ack     (mem_ack),
        .mem_rdata   (mem_rdata),
        .line_valid  (line_valid),
        .line_out    (line),
        .line_take   (line_take)
    );

    instr_aligner align_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .line_valid  (line_valid),
        .line_in     (line),
        .line_take   (line_take),
        .al_valid    (al_valid),
        .al_instr    (al_instr),
        .dec_ready   (dec_ready)
    );

    rvc_expander expand_i (
        .al_instr  (al_instr),
        .exp_instr (exp_instr)
    );

    instr_decoder decode_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .redirect  (redirect),
        .stall     (stall),
        .al_valid  (al_valid),
        .exp_instr (exp_instr),
        .dec_ready (dec_ready),
        .out_valid (out_valid),
        .out_instr (out_instr)
    );

endmodule

// ==== tb/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// ====================
// Memory image
// ====================

// Major opcode for a 32-bit word, spare codes give a fence
function automatic logic [6:0] opcode_for(input logic [3:0] sel);
    case (sel)
        4'd0:    return OPC_LUI;
        4'd1:    return OPC_AUIPC;
        4'd2:    return OPC_JAL;
        4'd3:    return OPC_JALR;
        4'd4:    return OPC_BRANCH;
        4'd5:    return OPC_LOAD;
        4'd6:    return OPC_STORE;
        4'd7:    return OPC_OP_IMM;
        4'd8:    return OPC_OP_IMM_32;
        4'd9:    return OPC_OP;
        4'd10:   return OPC_OP_32;
        4'd11:   return OPC_SYSTEM;
        default: return 7'b0001111;
    endcase
endfunction

// One halfword of the 4 KiB image, repeated over the address space
function automatic logic [HALF_W-1:0] half_at(input logic [VADDR_W-1:0] addr);
    logic [31:0]       h;
    logic [4:0]        rs2;
    logic [HALF_W-1:0] v;
    // Mix every halfword index bit of the window
    h = {21'd0, addr[11:1]} * 32'h9E37_79B1;
    h = h ^ (h >> 15);
    h = h * 32'h85EB_CA6B;
    h = h ^ (h >> 13);
    rs2 = (h[6:2] == 5'd0) ? 5'd1 : h[6:2];
    case (h[31:30])
        // Supported compressed forms
        2'd0: begin
            case (h[18:16])
                3'd0, 3'd5: v = {3'b000, h[12:2], 2'b01};
                3'd1, 3'd6: v = {3'b010, h[12:2], 2'b01};
                3'd2, 3'd7: v = {3'b101, h[12:2], 2'b01};
                3'd3:       v = {3'b100, 1'b0, h[11:7], rs2, 2'b10};
                default:    v = {3'b100, 1'b1, h[11:7], rs2, 2'b10};
            endcase
        end
        // Any compressed word
        2'd1:    v = {h[15:2], (h[1:0] == 2'b11) ? 2'b00 : h[1:0]};
        // Low half of a 32-bit word
        default: v = {h[15:7], opcode_for(h[23:20])};
    endcase
    return v;
endfunction

// Aligned 64-bit line as the memory returns it
function automatic logic [LINE_W-1:0] line_at(input logic [VADDR_W-1:0] addr);
    logic [VADDR_W-1:0] base;
    base = {addr[VADDR_W-1:3], 3'b000};
    return {half_at(base + VADDR_W'(6)), half_at(base + VADDR_W'(4)),
            half_at(base + VADDR_W'(2)), half_at(base)};
endfunction

// ====================
// Expansion and decode
// ====================

// Result is {illegal, word}
function automatic logic [32:0] expand_compressed(input logic [HALF_W-1:0] c);
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [20:0] joff;
    logic [32:0] res;
    rd   = c[11:7];
    rs2  = c[6:2];
    imm  = {{6{c[12]}}, c[12], c[6:2]};
    // CJ offset bits 11,4,9:8,10,6,7,3:1,5 from bit 12 down
    joff = {{10{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
    res  = {1'b1, 32'd0};
    if (c[1:0] == 2'b01 && c[15:13] == 3'b000) begin
        res = {1'b0, imm, rd, 3'b000, rd, OPC_OP_IMM};
    end else if (c[1:0] == 2'b01 && c[15:13] == 3'b010) begin
        res = {1'b0, imm, 5'd0, 3'b000, rd, OPC_OP_IMM};
    end else if (c[1:0] == 2'b01 && c[15:13] == 3'b101) begin
        res = {1'b0, joff[20], joff[10:1], joff[11], joff[19:12], 5'd0, OPC_JAL};
    end else if (c[1:0] == 2'b10 && c[15:13] == 3'b100 && rs2 != 5'd0) begin
        // Bit 12 picks C.ADD over C.MV
        res = {1'b0, 7'd0, rs2, c[12] ? rd : 5'd0, 3'b000, rd, OPC_OP};
    end
    return res;
endfunction

// Instruction the backend must see at a given PC
function automatic decoded_instr_t expected_instr(input logic [VADDR_W-1:0] pc);
    decoded_instr_t     d;
    logic [HALF_W-1:0]  lo;
    logic [32:0]        ex;
    logic [ILEN-1:0]    word;
    d            = '0;
    lo           = half_at(pc);
    d.pc         = pc;
    d.compressed = (lo[1:0] != 2'b11);
    if (d.compressed) begin
        ex        = expand_compressed(lo);
        word      = ex[31:0];
        d.illegal = ex[32];
    end else begin
        word = {half_at(pc + VADDR_W'(2)), lo};
    end
    d.word   = word;
    d.rd     = word[11:7];
    d.funct3 = word[14:12];
    d.rs1    = word[19:15];
    d.rs2    = word[24:20];
    d.cls    = CLS_UNKNOWN;
    case (word[6:0])
        OPC_LUI, OPC_AUIPC: begin
            d.cls = CLS_ALU;
            d.imm = {{32{word[31]}}, word[31:12], 12'h000};
        end
        OPC_JAL: begin
            d.cls = CLS_JAL;
            d.imm = {{43{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
        end
        OPC_BRANCH: begin
            d.cls = CLS_BRANCH;
            d.imm = {{51{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
        end
        OPC_STORE: begin
            d.cls = CLS_STORE;
            d.imm = {{52{word[31]}}, word[31:25], word[11:7]};
        end
        OPC_JALR, OPC_LOAD, OPC_OP_IMM, OPC_OP_IMM_32, OPC_SYSTEM: begin
            if (word[6:0] == OPC_JALR) d.cls = CLS_JALR;
            else if (word[6:0] == OPC_LOAD) d.cls = CLS_LOAD;
            else if (word[6:0] == OPC_OP_IMM_32) d.cls = CLS_ALU_W;
            else if (word[6:0] == OPC_SYSTEM) d.cls = CLS_SYSTEM;
            else d.cls = CLS_ALU;
            d.imm = {{52{word[31]}}, word[31:20]};
        end
        OPC_OP, OPC_OP_32: begin
            if (word[31:25] == 7'd1) d.cls = CLS_MUL;
            else if (word[6:0] == OPC_OP_32) d.cls = CLS_ALU_W;
            else d.cls = CLS_ALU;
        end
        default: d.cls = CLS_UNKNOWN;
    endcase
    if (d.illegal) begin
        d.cls = CLS_UNKNOWN;
        d.imm = '0;
    end
    return d;
endfunction

`endif

// ==== tb/tb_rvc_frontend.sv ====
module tb_rvc_frontend import rvc_frontend_pkg::*; ();

    localparam int N_INSTR    = 400;
    // Up to 6 cycles per instruction, plus margin
    localparam int MAX_CYCLES = N_INSTR * 6 + 600;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               stall;
    logic               redirect;
    logic [VADDR_W-1:0] redirect_pc;
    logic               mem_req;
    logic [VADDR_W-1:0] mem_addr;
    logic               mem_ack;
    logic [LINE_W-1:0]  mem_rdata;
    logic               out_valid;
    decoded_instr_t     out_instr;

    // Memory responder
    logic               req_open;
    logic [VADDR_W-1:0] req_addr;
    int                 ack_wait;

    // Backend and model
    int                 stall_left;
    int                 delivered;
    int                 cycles;
    logic [VADDR_W-1:0] exp_pc;
    logic               hold_pending;
    decoded_instr_t     held_instr;
    decoded_instr_t     model_instr;

    `include "tb_ref_model.svh"

    rvc_frontend dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_ack     (mem_ack),
        .mem_rdata   (mem_rdata),
        .out_valid   (out_valid),
        .out_instr   (out_instr)
    );

    always #4 clk = ~clk;

    // ====================
    // Checks
    // ====================

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s: got %0h, expected %0h", $time, what, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "Mismatch in %s", what);
        end
    endtask

    task automatic compare_instr(input string tag, input decoded_instr_t got,
                                 input decoded_instr_t exp);
        check_value({tag, " pc"}, 64'(got.pc), 64'(exp.pc));
        check_value({tag, " word"}, 64'(got.word), 64'(exp.word));
        check_value({tag, " compressed"}, 64'(got.compressed), 64'(exp.compressed));
        check_value({tag, " illegal"}, 64'(got.illegal), 64'(exp.illegal));
        check_value({tag, " class"}, 64'(got.cls), 64'(exp.cls));
        check_value({tag, " rd"}, 64'(got.rd), 64'(exp.rd));
        check_value({tag, " rs1"}, 64'(got.rs1), 64'(exp.rs1));
        check_value({tag, " rs2"}, 64'(got.rs2), 64'(exp.rs2));
        check_value({tag, " funct3"}, 64'(got.funct3), 64'(exp.funct3));
        check_value({tag, " imm"}, got.imm, exp.imm);
    endtask

    // ====================
    // Stimulus
    // ====================

    // Four-phase memory, 0 to 4 cycles to ack
    task automatic respond_memory();
        if (!mem_ack) begin
            if (mem_req) begin
                if (!req_open) begin
                    req_open = 1'b1;
                    req_addr = mem_addr;
                    ack_wait = $urandom_range(4, 0);
                end
                check_value("mem_addr held", 64'(mem_addr), 64'(req_addr));
                check_value("mem_addr aligned", 64'(mem_addr[2:0]), 64'd0);
                if (ack_wait == 0) begin
                    mem_ack   = 1'b1;
                    mem_rdata = line_at(mem_addr);
                end else begin
                    ack_wait = ack_wait - 1;
                end
            end
        end else if (!mem_req) begin
            // Request dropped, close the handshake
            mem_ack  = 1'b0;
            req_open = 1'b0;
        end
    endtask

    // Stall stretches and redirect pulses
    task automatic drive_backend();
        redirect = 1'b0;
        if (stall_left > 0) begin
            stall      = 1'b1;
            stall_left = stall_left - 1;
        end else if ($urandom_range(7, 0) == 0) begin
            stall      = 1'b1;
            stall_left = $urandom_range(5, 0);
        end else begin
            stall = 1'b0;
        end
        // First instruction comes from the reset address
        if (delivered > 0 && $urandom_range(39, 0) == 0) begin
            redirect    = 1'b1;
            redirect_pc = {RESET_PC[VADDR_W-1:12], 11'($urandom), 1'b0};
        end
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        rst_n        = 1'b0;
        stall        = 1'b0;
        redirect     = 1'b0;
        redirect_pc  = '0;
        mem_ack      = 1'b0;
        mem_rdata    = '0;
        req_open     = 1'b0;
        req_addr     = '0;
        ack_wait     = 0;
        stall_left   = 0;
        delivered    = 0;
        cycles       = 0;
        exp_pc       = RESET_PC;
        hold_pending = 1'b0;
        held_instr   = '0;
        model_instr  = '0;
        void'($urandom(32'h3931));

        // Ports quiet during reset
        repeat (5) begin
            @(negedge clk);
            check_value("mem_req in reset", 64'(mem_req), 64'd0);
            check_value("out_valid in reset", 64'(out_valid), 64'd0);
        end
        rst_n = 1'b1;

        while (delivered < N_INSTR) begin
            @(negedge clk);
            cycles = cycles + 1;
            if (cycles > MAX_CYCLES) begin
                $display("Timeout after %0d cycles, %0d of %0d instructions delivered",
                         cycles, delivered, N_INSTR);
                $display("ERRORS FOUND");
                $fatal(1, "Timeout");
            end
            respond_memory();
            // Output frozen by the stall of the last cycle
            if (hold_pending) begin
                check_value("out_valid under stall", 64'(out_valid), 64'd1);
                compare_instr("held", out_instr, held_instr);
            end
            drive_backend();
            if (redirect) begin
                exp_pc = redirect_pc;
            end else if (out_valid && !stall) begin
                model_instr = expected_instr(exp_pc);
                compare_instr("delivered", out_instr, model_instr);
                exp_pc    = exp_pc + (model_instr.compressed ? VADDR_W'(2) : VADDR_W'(4));
                delivered = delivered + 1;
            end
            hold_pending = out_valid && stall && !redirect;
            held_instr   = out_instr;
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+tb
hw/rvc_frontend_pkg.sv
hw/line_fetch.sv
hw/instr_aligner.sv
hw/rvc_expander.sv
hw/instr_decoder.sv
hw/rvc_frontend.sv
tb/tb_rvc_frontend.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the frontend testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary -j 0 -f build.f --top-module tb_rvc_frontend -Mdir obj_dir &&
./obj_dir/Vtb_rvc_frontend ||
{ echo "simulation did not pass"; exit 1; }
